//--- mp8.f
+incdir+common
common/mp8_pkg.sv
source/mp8_decoder.sv
datapath/mp8_register_file.sv
datapath/mp8_alu.sv
source/mp8_sequencer.sv
source/mp8_top.sv
tests/mp8_assertions.sv
tests/mp8_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile mp8_tb with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module mp8_tb -f mp8.f -o mp8_sim \
   && ./obj_dir/mp8_sim > sim.log 2>&1 \
   || echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -q "^TEST OK$" sim.log 2>/dev/null && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

//--- tests/mp8_tb.sv
`timescale 1ns/1ps
`include "mp8_config.svh"

module mp8_tb;

   logic            clk = 1'b0;
   logic            rst = 1'b1;
   mp8_pkg::addr_t  address;
   logic            bram_enable;
   mp8_pkg::instr_t instruction = '0;
   mp8_pkg::data_t  in_port = '0;
   mp8_pkg::data_t  out_port;
   mp8_pkg::data_t  port_id;
   logic            write_strobe;
   logic            read_strobe;

   mp8_pkg::instr_t prog [4096];
   mp8_pkg::data_t  in_table [256];
   logic [15:0]     writes [$];    // {port_id, out_port}
   mp8_pkg::data_t  reads [$];
   mp8_pkg::addr_t  fetches [$];
   int              wr_ptr;
   int              checks;
   int              errors;
   int              timeouts;

   mp8_top uut (
      .clk         (clk),
      .rst         (rst),
      .address     (address),
      .bram_enable (bram_enable),
      .instruction (instruction),
      .in_port     (in_port),
      .out_port    (out_port),
      .port_id     (port_id),
      .write_strobe(write_strobe),
      .read_strobe (read_strobe)
   );

   always #10 clk = ~clk;

   ////////////////////
   // program memory and port models
   always @(negedge clk)
   begin
      if (bram_enable === 1'b1)
      begin
         instruction <= prog[address];
         fetches.push_back(address);
      end
      in_port <= in_table[port_id];
      if (write_strobe === 1'b1)
         writes.push_back({port_id, out_port});
      if (read_strobe === 1'b1)
         reads.push_back(port_id);
   end

   ////////////////////
   // instruction encoding
   function automatic mp8_pkg::instr_t const_form(input logic [5:0] op, input int sx,
                                                  input int kk);
      return {op | 6'h01, sx[3:0], kk[7:0]};
   endfunction

   function automatic mp8_pkg::instr_t reg_form(input logic [5:0] op, input int sx,
                                                input int sy);
      return {op, sx[3:0], sy[3:0], 4'h0};
   endfunction

   function automatic mp8_pkg::instr_t flow_form(input logic [5:0] op, input int target);
      return {op, target[11:0]};
   endfunction

   function automatic logic [5:0] cond_op(input logic [5:0] op, input logic [2:0] cond);
      return {1'b1, cond, op[1:0]};
   endfunction

   task automatic emit(input mp8_pkg::instr_t instr);
      prog[wr_ptr] = instr;
      wr_ptr++;
   endtask

   ////////////////////
   // reset, waits and compares
   task automatic begin_program();
      @(negedge clk);
      rst = 1'b1;
      for (int i = 0; i < 4096; i++)
         prog[i] = flow_form(`MP8_OP_JUMP, i);   // empty slots park the core
      wr_ptr = 0;
   endtask

   task automatic run_program();
      repeat (16) @(negedge clk);
      writes.delete();
      reads.delete();
      fetches.delete();
      rst = 1'b0;
   endtask

   task automatic wait_writes(input int n);
      int cycles;
      cycles = 0;
      while (writes.size() < n && cycles < 600)
      begin
         @(negedge clk);
         cycles++;
      end
      if (writes.size() < n)
      begin
         timeouts++;
         $display("timeout: %0d of %0d port writes seen", writes.size(), n);
      end
   endtask

   task automatic wait_fetches(input int n);
      int cycles;
      cycles = 0;
      while (fetches.size() < n && cycles < 600)
      begin
         @(negedge clk);
         cycles++;
      end
      if (fetches.size() < n)
      begin
         timeouts++;
         $display("timeout: %0d of %0d fetches seen", fetches.size(), n);
      end
   endtask

   task automatic check_data(input string name, input mp8_pkg::data_t got,
                             input mp8_pkg::data_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_addr(input string name, input mp8_pkg::addr_t got,
                             input mp8_pkg::addr_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic expect_write(input mp8_pkg::data_t port, input mp8_pkg::data_t value);
      logic [15:0] pair;
      if (writes.size() == 0)
      begin
         errors++;
         $display("missing port write of 0x%h to port 0x%h", value, port);
      end
      else
      begin
         pair = writes.pop_front();
         check_data("port_id", pair[15:8], port);
         check_data("out_port", pair[7:0], value);
      end
   endtask

   ////////////////////
   // directed tests
   task automatic load_and_output();
      begin_program();
      emit(const_form(`MP8_OP_LOAD, 0, 8'h3C));
      emit(const_form(`MP8_OP_LOAD, 1, 8'hA5));
      emit(const_form(`MP8_OP_LOAD, 3, 8'hFF));
      emit(reg_form(`MP8_OP_LOAD, 4, 1));         // register copy
      emit(const_form(`MP8_OP_OUTPUT, 0, 8'h10));
      emit(const_form(`MP8_OP_OUTPUT, 1, 8'h11));
      emit(const_form(`MP8_OP_OUTPUT, 3, 8'h12));
      emit(const_form(`MP8_OP_OUTPUT, 4, 8'h13));
      run_program();
      wait_writes(4);
      expect_write(8'h10, 8'h3C);
      expect_write(8'h11, 8'hA5);
      expect_write(8'h12, 8'hFF);
      expect_write(8'h13, 8'hA5);
   endtask

   task automatic logic_and_arith();
      mp8_pkg::data_t a;
      mp8_pkg::data_t b;
      logic [5:0]     ops [7];
      mp8_pkg::data_t exp_v [7];
      logic [8:0]     sum;
      logic           borrow;
      ops[0] = `MP8_OP_AND;
      ops[1] = `MP8_OP_OR;
      ops[2] = `MP8_OP_XOR;
      ops[3] = `MP8_OP_ADD;
      ops[4] = `MP8_OP_ADD | 6'h02;   // ADDCY
      ops[5] = `MP8_OP_SUB;
      ops[6] = `MP8_OP_SUB | 6'h02;   // SUBCY
      for (int iter = 0; iter < 3; iter++)
      begin
         a = mp8_pkg::data_t'($urandom);
         b = mp8_pkg::data_t'($urandom);
         sum = {1'b0, a} + {1'b0, b};
         borrow = (a < b);
         exp_v[0] = a & b;
         exp_v[1] = a | b;
         exp_v[2] = a ^ b;
         exp_v[3] = sum[7:0];
         exp_v[4] = a + b + sum[8];   // carry left by ADD
         exp_v[5] = a - b;
         exp_v[6] = a - b - borrow;   // borrow left by SUB
         begin_program();
         emit(const_form(`MP8_OP_LOAD, 0, a));
         emit(const_form(`MP8_OP_LOAD, 1, b));
         for (int k = 0; k < 7; k++)
         begin
            emit(reg_form(`MP8_OP_LOAD, 2, 0));
            emit(reg_form(ops[k], 2, 1));
            emit(const_form(`MP8_OP_OUTPUT, 2, 8'h20 + k));
         end
         run_program();
         wait_writes(7);
         for (int k = 0; k < 7; k++)
            expect_write(8'h20 + k, exp_v[k]);
      end
   endtask

   task automatic flag_branches();
      mp8_pkg::data_t a;
      mp8_pkg::data_t b;
      mp8_pkg::data_t t;
      logic [2:0]     conds [4];
      logic           fz;
      logic           fc;
      logic           taken;
      conds[0] = `MP8_COND_Z;
      conds[1] = `MP8_COND_NZ;
      conds[2] = `MP8_COND_C;
      conds[3] = `MP8_COND_NC;
      for (int op_sel = 0; op_sel < 2; op_sel++)
         for (int k = 0; k < 4; k++)
            for (int same = 0; same < 2; same++)
            begin
               a = mp8_pkg::data_t'($urandom);
               b = same ? a : mp8_pkg::data_t'($urandom);
               t = a & b;
               fz = (op_sel == 0) ? (a == b) : (t == 8'h00);
               fc = (op_sel == 0) ? (a < b) : ^t;        // borrow or parity
               taken = (k == 0) ? fz : (k == 1) ? !fz : (k == 2) ? fc : !fc;
               begin_program();
               emit(const_form(`MP8_OP_LOAD, 0, a));
               emit(const_form(`MP8_OP_LOAD, 1, b));
               emit(reg_form(op_sel == 0 ? `MP8_OP_COMPARE : `MP8_OP_TEST, 0, 1));
               emit(flow_form(cond_op(`MP8_OP_JUMP, conds[k]), 6));
               emit(const_form(`MP8_OP_LOAD, 2, 8'hAA));  // not taken
               emit(flow_form(`MP8_OP_JUMP, 7));
               emit(const_form(`MP8_OP_LOAD, 2, 8'h55));  // taken
               emit(const_form(`MP8_OP_OUTPUT, 2, 8'h40));
               run_program();
               wait_writes(1);
               expect_write(8'h40, taken ? 8'h55 : 8'hAA);
            end
   endtask

   task automatic nested_calls();
      mp8_pkg::data_t order [6];
      order = '{8'h01, 8'h02, 8'h03, 8'h12, 8'h11, 8'hE0};
      begin_program();
      emit(flow_form(`MP8_OP_CALL, 16));
      emit(const_form(`MP8_OP_LOAD, 1, 8'hE0));
      emit(const_form(`MP8_OP_OUTPUT, 1, 8'h50));
      for (int d = 1; d <= 3; d++)
      begin
         wr_ptr = 16 * d;                           // one routine per depth
         emit(const_form(`MP8_OP_LOAD, 1, d));
         emit(const_form(`MP8_OP_OUTPUT, 1, 8'h50));
         if (d < 3)
         begin
            emit(flow_form(`MP8_OP_CALL, 16 * (d + 1)));
            emit(const_form(`MP8_OP_LOAD, 1, 8'h10 + d));
            emit(const_form(`MP8_OP_OUTPUT, 1, 8'h50));
         end
         emit(flow_form(`MP8_OP_RETURN, 0));
      end
      run_program();
      wait_writes(6);
      for (int i = 0; i < 6; i++)
         expect_write(8'h50, order[i]);
   endtask

   task automatic port_input();
      mp8_pkg::data_t p1;
      mp8_pkg::data_t p2;
      p1 = mp8_pkg::data_t'($urandom);
      p2 = mp8_pkg::data_t'($urandom);
      begin_program();
      emit(const_form(`MP8_OP_INPUT, 0, p1));      // constant port
      emit(const_form(`MP8_OP_OUTPUT, 0, 8'h60));
      emit(const_form(`MP8_OP_LOAD, 1, p2));
      emit(reg_form(`MP8_OP_INPUT, 2, 1));         // port from s1
      emit(const_form(`MP8_OP_OUTPUT, 2, 8'h61));
      run_program();
      wait_writes(2);
      if (reads.size() != 2)
      begin
         errors++;
         $display("expected 2 read strobes, saw %0d", reads.size());
      end
      else
      begin
         check_data("port_id", reads[0], p1);
         check_data("port_id", reads[1], p2);
      end
      expect_write(8'h60, in_table[p1]);
      expect_write(8'h61, in_table[p2]);
   endtask

   task automatic stack_underflow();
      begin_program();
      emit(const_form(`MP8_OP_LOAD, 0, 8'h77));
      emit(const_form(`MP8_OP_OUTPUT, 0, 8'h70));
      emit(flow_form(`MP8_OP_RETURN, 0));          // empty stack
      run_program();
      wait_writes(2);
      expect_write(8'h70, 8'h77);
      expect_write(8'h70, 8'h77);                  // program ran again
      wait_fetches(4);
      if (fetches.size() >= 4)
      begin
         check_addr("address", fetches[0], `MP8_RESET_VECTOR);
         check_addr("address", fetches[1], 12'h001);
         check_addr("address", fetches[2], 12'h002);
         check_addr("address", fetches[3], `MP8_RESET_VECTOR);
      end
   endtask

   initial
   begin
      checks = 0;
      errors = 0;
      timeouts = 0;
      wr_ptr = 0;
      void'($urandom(63));
      for (int i = 0; i < 256; i++)
         in_table[i] = mp8_pkg::data_t'($urandom);
      load_and_output();
      logic_and_arith();
      flag_branches();
      nested_calls();
      port_input();
      stack_underflow();
      $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

//--- tests/mp8_assertions.sv
`timescale 1ns/1ps

module mp8_assertions (
   input logic           clk,
   input logic           rst,
   input logic           bram_enable,
   input logic           decode_phase,   // sequencer execute clock
   input mp8_pkg::addr_t address,
   input logic           write_strobe,
   input logic           read_strobe
);

   ////////////////////
   // port side
   strobes_exclusive: assert property (@(posedge clk) disable iff (rst)
      !(write_strobe && read_strobe))
      else $error("write_strobe and read_strobe high together");

   ////////////////////
   // program memory side
   single_fetch: assert property (@(posedge clk) disable iff (rst)
      bram_enable |-> !$past(bram_enable))
      else $error("bram_enable high on two consecutive clocks");

   // pc only moves on the edge that ends the execute clock
   address_hold: assert property (@(posedge clk) disable iff (rst)
      !$past(decode_phase) |-> (address == $past(address)))
      else $error("address changed outside the edge that ends the execute phase");

endmodule

bind mp8_top mp8_assertions u_assertions (
   .clk         (clk),
   .rst         (rst),
   .bram_enable (bram_enable),
   .decode_phase(decode_phase),
   .address     (address),
   .write_strobe(write_strobe),
   .read_strobe (read_strobe)
);

//--- source/mp8_top.sv
`timescale 1ns/1ps

module mp8_top (
   input  logic            clk,
   input  logic            rst,
   output mp8_pkg::addr_t  address,
   output logic            bram_enable,
   input  mp8_pkg::instr_t instruction,
   input  mp8_pkg::data_t  in_port,
   output mp8_pkg::data_t  out_port,
   output mp8_pkg::data_t  port_id,
   output logic            write_strobe,
   output logic            read_strobe
);

   mp8_pkg::dec_t     dec;
   mp8_pkg::flags_t   flags;
   mp8_pkg::data_t    sx_data;
   mp8_pkg::data_t    sy_data;
   mp8_pkg::reg_idx_t wr_idx;
   mp8_pkg::data_t    wr_data;
   logic              wr_en;
   logic              decode_phase;
   logic              execute_phase;

   mp8_decoder u_decoder (
      .instruction(instruction),
      .dec        (dec)
   );

   mp8_sequencer u_sequencer (
      .clk          (clk),
      .rst          (rst),
      .dec          (dec),
      .flags        (flags),
      .address      (address),
      .bram_enable  (bram_enable),
      .decode_phase (decode_phase),
      .execute_phase(execute_phase)
   );

   mp8_alu u_alu (
      .clk          (clk),
      .rst          (rst),
      .decode_phase (decode_phase),
      .execute_phase(execute_phase),
      .dec          (dec),
      .sx_data      (sx_data),
      .sy_data      (sy_data),
      .in_port      (in_port),
      .flags        (flags),
      .wr_en        (wr_en),
      .wr_idx       (wr_idx),
      .wr_data      (wr_data),
      .port_id      (port_id),
      .out_port     (out_port),
      .write_strobe (write_strobe),
      .read_strobe  (read_strobe)
   );

   mp8_register_file u_register_file (
      .clk      (clk),
      .rd_a_idx (dec.sx),
      .rd_a_data(sx_data),
      .rd_b_idx (dec.sy),
      .rd_b_data(sy_data),
      .wr_en    (wr_en),
      .wr_idx   (wr_idx),
      .wr_data  (wr_data)
   );

endmodule

//--- source/mp8_sequencer.sv
`timescale 1ns/1ps
`include "mp8_config.svh"

module mp8_sequencer (
   input  logic            clk,
   input  logic            rst,
   input  mp8_pkg::dec_t   dec,
   input  mp8_pkg::flags_t flags,
   output mp8_pkg::addr_t  address,
   output logic            bram_enable,
   output logic            decode_phase,   // execute clock of the sequencer
   output logic            execute_phase   // one clock later, ALU writeback
);

   localparam int stack_depth = 1 << `MP8_STACK_DEPTH_LOG2;

   mp8_pkg::phase_e phase;
   mp8_pkg::addr_t  pc;
   mp8_pkg::addr_t  pc_inc;
   mp8_pkg::addr_t  pop_addr;
   mp8_pkg::addr_t  stack_mem [stack_depth];
   logic [`MP8_STACK_DEPTH_LOG2:0]   sp;       // entries pushed
   logic [`MP8_STACK_DEPTH_LOG2-1:0] sp_top;
   logic            started;
   logic            restart;                   // stack over/underflow
   logic            cond_ok;
   logic            push;

   assign address      = pc;
   assign pc_inc       = pc + 12'd1;
   assign sp_top       = sp[`MP8_STACK_DEPTH_LOG2-1:0] - 1'b1;
   assign pop_addr     = stack_mem[sp_top];
   assign bram_enable  = started & (phase == mp8_pkg::ph_fetch);
   assign decode_phase = started & (phase == mp8_pkg::ph_execute);

   always_comb
   begin
      case (dec.cond)
         `MP8_COND_Z:  cond_ok = flags.z;
         `MP8_COND_NZ: cond_ok = ~flags.z;
         `MP8_COND_C:  cond_ok = flags.c;
         `MP8_COND_NC: cond_ok = ~flags.c;
         default:      cond_ok = 1'b1;
      endcase
   end

   assign push = decode_phase & cond_ok & (dec.flow == mp8_pkg::flow_call) &
                 (sp != stack_depth);

   ////////////////////
   // phase, pc and stack pointer
   always_ff @(posedge clk)
   begin
      if (rst | restart)
      begin
         phase         <= mp8_pkg::ph_execute;   // first clock after reset fetches
         started       <= 1'b0;
         execute_phase <= 1'b0;
         restart       <= 1'b0;
         pc            <= `MP8_RESET_VECTOR;
         sp            <= '0;
      end
      else
      begin
         started       <= 1'b1;
         execute_phase <= decode_phase;
         phase         <= (phase == mp8_pkg::ph_fetch) ? mp8_pkg::ph_execute
                                                      : mp8_pkg::ph_fetch;
         if (decode_phase)
         begin
            pc <= pc_inc;
            if (cond_ok)
            begin
               case (dec.flow)
                  mp8_pkg::flow_jump: pc <= dec.target;
                  mp8_pkg::flow_call:
                  begin
                     if (sp == stack_depth)
                     begin
                        restart <= 1'b1;
                        pc      <= `MP8_RESET_VECTOR;
                     end
                     else
                     begin
                        sp <= sp + 1'b1;
                        pc <= dec.target;
                     end
                  end
                  mp8_pkg::flow_ret:
                  begin
                     if (sp == '0)
                     begin
                        restart <= 1'b1;
                        pc      <= `MP8_RESET_VECTOR;
                     end
                     else
                     begin
                        sp <= sp - 1'b1;
                        pc <= pop_addr;
                     end
                  end
                  default: ;
               endcase
            end
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (push)
         stack_mem[sp[`MP8_STACK_DEPTH_LOG2-1:0]] <= pc_inc;   // return address
   end

endmodule

//--- datapath/mp8_alu.sv
`timescale 1ns/1ps

module mp8_alu (
   input  logic              clk,
   input  logic              rst,
   input  logic              decode_phase,    // instruction valid
   input  logic              execute_phase,   // writeback clock
   input  mp8_pkg::dec_t     dec,
   input  mp8_pkg::data_t    sx_data,
   input  mp8_pkg::data_t    sy_data,
   input  mp8_pkg::data_t    in_port,
   output mp8_pkg::flags_t   flags,
   output logic              wr_en,
   output mp8_pkg::reg_idx_t wr_idx,
   output mp8_pkg::data_t    wr_data,
   output mp8_pkg::data_t    port_id,
   output mp8_pkg::data_t    out_port,
   output logic              write_strobe,
   output logic              read_strobe
);

   mp8_pkg::data_t    operand_b;
   mp8_pkg::data_t    and_v;
   mp8_pkg::data_t    res_d;
   mp8_pkg::data_t    res_q;
   mp8_pkg::data_t    port_q;
   mp8_pkg::reg_idx_t sx_q;
   logic [8:0]        sum;
   logic [8:0]        diff;          // bit 8 is the borrow
   logic              cin;
   logic              carry_d;
   logic              carry_q;
   logic              use_carry_q;
   logic              write_q;
   logic              flag_q;

   assign operand_b = dec.use_const ? dec.kk : sy_data;
   assign cin       = dec.use_carry & flags.c;
   assign and_v     = sx_data & operand_b;
   assign sum       = {1'b0, sx_data} + {1'b0, operand_b} + {8'd0, cin};
   assign diff      = {1'b0, sx_data} - {1'b0, operand_b} - {8'd0, cin};

   always_comb
   begin
      res_d   = operand_b;
      carry_d = 1'b0;
      case (dec.alu_op)
         mp8_pkg::alu_and:                   res_d = and_v;
         mp8_pkg::alu_or:                    res_d = sx_data | operand_b;
         mp8_pkg::alu_xor:                   res_d = sx_data ^ operand_b;
         mp8_pkg::alu_add:                   {carry_d, res_d} = sum;
         mp8_pkg::alu_sub, mp8_pkg::alu_compare: {carry_d, res_d} = diff;
         mp8_pkg::alu_test:
         begin
            res_d   = and_v;
            carry_d = ^{and_v, cin};   // odd parity
         end
         default: ;
      endcase
      if (dec.is_input)
         res_d = in_port;
   end

   ////////////////////
   // decode phase capture
   always_ff @(posedge clk)
   begin
      if (decode_phase)
      begin
         res_q       <= res_d;
         carry_q     <= carry_d;
         sx_q        <= dec.sx;
         use_carry_q <= dec.use_carry;
         port_q      <= operand_b;
         if (dec.is_output)
            out_port <= sx_data;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         write_q      <= 1'b0;
         flag_q       <= 1'b0;
         write_strobe <= 1'b0;
      end
      else
      begin
         write_strobe <= decode_phase & dec.is_output;
         if (decode_phase)
         begin
            write_q <= dec.is_input | (dec.alu_valid & (dec.alu_op != mp8_pkg::alu_test) &
                                       (dec.alu_op != mp8_pkg::alu_compare));
            flag_q  <= dec.alu_valid & (dec.alu_op != mp8_pkg::alu_load);
         end
      end
   end

   ////////////////////
   // writeback clock
   always_ff @(posedge clk)
   begin
      if (rst)
         flags <= '0;
      else if (execute_phase & flag_q)
      begin
         flags.c <= carry_q;
         flags.z <= (res_q == '0) & (~use_carry_q | flags.z);  // carry forms chain Z
      end
   end

   assign wr_en   = execute_phase & write_q;
   assign wr_idx  = sx_q;
   assign wr_data = res_q;

   assign read_strobe = decode_phase & dec.is_input;
   assign port_id     = decode_phase ? operand_b : port_q;  // held for write_strobe

endmodule

//--- datapath/mp8_register_file.sv
`timescale 1ns/1ps
`include "mp8_config.svh"

module mp8_register_file (
   input  logic              clk,
   input  mp8_pkg::reg_idx_t rd_a_idx,
   output mp8_pkg::data_t    rd_a_data,
   input  mp8_pkg::reg_idx_t rd_b_idx,
   output mp8_pkg::data_t    rd_b_data,
   input  logic              wr_en,
   input  mp8_pkg::reg_idx_t wr_idx,
   input  mp8_pkg::data_t    wr_data
);

   mp8_pkg::data_t regs [`MP8_NUM_REGS];

   initial
   begin
      for (int i = 0; i < `MP8_NUM_REGS; i++)
         regs[i] = '0;
   end

   assign rd_a_data = regs[rd_a_idx];   // sx
   assign rd_b_data = regs[rd_b_idx];   // sy

   always_ff @(posedge clk)
   begin
      if (wr_en)
         regs[wr_idx] <= wr_data;
   end

endmodule

//--- source/mp8_decoder.sv
`timescale 1ns/1ps
`include "mp8_config.svh"

module mp8_decoder (
   input  mp8_pkg::instr_t instruction,
   output mp8_pkg::dec_t   dec
);

   localparam logic [5:0] op_jump   = `MP8_OP_JUMP;
   localparam logic [5:0] op_call   = `MP8_OP_CALL;
   localparam logic [5:0] op_return = `MP8_OP_RETURN;

   logic [5:0] opcode;
   logic [5:0] op5;                 // opcodes with a 5-bit match
   logic [5:0] op4;                 // opcodes with a 4-bit match, bit 1 is carry
   logic       carry_group;
   logic       cond_form;

   assign opcode      = instruction[17:12];
   assign op5         = {opcode[5:1], 1'b0};
   assign op4         = {opcode[5:2], 2'b00};
   assign carry_group = (op4 == `MP8_OP_ADD) | (op4 == `MP8_OP_SUB) |
                        (op4 == `MP8_OP_TEST) | (op4 == `MP8_OP_COMPARE);
   assign cond_form   = (opcode[5:4] == 2'b11);

   always_comb
   begin
      dec = '0;
      dec.sx        = instruction[11:8];
      dec.sy        = instruction[7:4];
      dec.kk        = instruction[7:0];
      dec.target    = instruction[11:0];
      dec.use_const = opcode[0];
      dec.use_carry = carry_group & opcode[1];
      dec.is_input  = (op5 == `MP8_OP_INPUT);
      dec.is_output = (op5 == `MP8_OP_OUTPUT);
      dec.flow      = mp8_pkg::flow_seq;
      dec.cond      = `MP8_COND_ALWAYS;

      ////////////////////
      // register operations
      dec.alu_valid = 1'b1;
      dec.alu_op    = mp8_pkg::alu_load;
      if (op5 == `MP8_OP_LOAD)         dec.alu_op = mp8_pkg::alu_load;
      else if (op5 == `MP8_OP_AND)     dec.alu_op = mp8_pkg::alu_and;
      else if (op5 == `MP8_OP_OR)      dec.alu_op = mp8_pkg::alu_or;
      else if (op5 == `MP8_OP_XOR)     dec.alu_op = mp8_pkg::alu_xor;
      else if (op4 == `MP8_OP_ADD)     dec.alu_op = mp8_pkg::alu_add;
      else if (op4 == `MP8_OP_SUB)     dec.alu_op = mp8_pkg::alu_sub;
      else if (op4 == `MP8_OP_TEST)    dec.alu_op = mp8_pkg::alu_test;
      else if (op4 == `MP8_OP_COMPARE) dec.alu_op = mp8_pkg::alu_compare;
      else dec.alu_valid = 1'b0;    // io, flow and dropped opcodes

      ////////////////////
      // program flow
      if (opcode == op_jump)
         dec.flow = mp8_pkg::flow_jump;
      else if (opcode == op_call)
         dec.flow = mp8_pkg::flow_call;
      else if (opcode == op_return)
         dec.flow = mp8_pkg::flow_ret;
      else if (cond_form)
      begin
         dec.cond = opcode[4:2];
         if (opcode[1:0] == op_jump[1:0])        dec.flow = mp8_pkg::flow_jump;
         else if (opcode[1:0] == op_call[1:0])   dec.flow = mp8_pkg::flow_call;
         else if (opcode[1:0] == op_return[1:0]) dec.flow = mp8_pkg::flow_ret;
      end
   end

endmodule

//--- common/mp8_pkg.sv
package mp8_pkg;

   ////////////////////
   // widths
   typedef logic [7:0]  data_t;     // register, port or constant
   typedef logic [11:0] addr_t;     // program address
   typedef logic [17:0] instr_t;
   typedef logic [3:0]  reg_idx_t;

   typedef struct packed {
      logic c;
      logic z;
   } flags_t;

   typedef logic [2:0] alu_op_t;
   localparam alu_op_t alu_load    = 3'd0;
   localparam alu_op_t alu_and     = 3'd1;
   localparam alu_op_t alu_or      = 3'd2;
   localparam alu_op_t alu_xor     = 3'd3;
   localparam alu_op_t alu_add     = 3'd4;
   localparam alu_op_t alu_sub     = 3'd5;
   localparam alu_op_t alu_test    = 3'd6;
   localparam alu_op_t alu_compare = 3'd7;

   typedef logic [1:0] flow_t;
   localparam flow_t flow_seq  = 2'd0;
   localparam flow_t flow_jump = 2'd1;
   localparam flow_t flow_call = 2'd2;
   localparam flow_t flow_ret  = 2'd3;

   typedef logic [2:0] cond_t;      // same coding as instruction[16:14]

   typedef struct packed {
      alu_op_t  alu_op;
      logic     alu_valid;
      logic     use_carry;          // ADDCY, SUBCY, TESTCY, COMPARECY
      logic     use_const;          // second operand is kk
      reg_idx_t sx;
      reg_idx_t sy;
      data_t    kk;
      addr_t    target;
      flow_t    flow;
      cond_t    cond;
      logic     is_input;
      logic     is_output;
   } dec_t;

   typedef enum logic {ph_fetch, ph_execute} phase_e;

endpackage

//--- common/mp8_config.svh
`ifndef MP8_CONFIG_SVH
`define MP8_CONFIG_SVH

////////////////////
// core sizing
`define MP8_NUM_REGS          16
`define MP8_STACK_DEPTH_LOG2  5       // 32 return addresses
`define MP8_RESET_VECTOR      12'h000

////////////////////
// opcode field, instruction[17:12]
// bit 0 selects the constant operand, bit 1 the carry variant of add/sub/test/compare
`define MP8_OP_LOAD     6'h00
`define MP8_OP_AND      6'h02
`define MP8_OP_OR       6'h04
`define MP8_OP_XOR      6'h06
`define MP8_OP_INPUT    6'h08
`define MP8_OP_TEST     6'h0C
`define MP8_OP_ADD      6'h10
`define MP8_OP_SUB      6'h18
`define MP8_OP_COMPARE  6'h1C
`define MP8_OP_OUTPUT   6'h2C
`define MP8_OP_CALL     6'h20   // unconditional forms
`define MP8_OP_JUMP     6'h22
`define MP8_OP_RETURN   6'h25

// conditional flow is {1'b1, cond, op[1:0]} in instruction[17:12]
`define MP8_COND_ALWAYS 3'b000
`define MP8_COND_Z      3'b100
`define MP8_COND_NZ     3'b101
`define MP8_COND_C      3'b110
`define MP8_COND_NC     3'b111

`endif
